/* include/hdmi_tpm_defines.svh */
`ifndef HDMI_TPM_DEFINES_SVH
`define HDMI_TPM_DEFINES_SVH

// ************************************************************
// Stream geometry
// ************************************************************

// Number of parallel video channels, all sharing one timing code sequence
`define HDMI_TPM_NUM_CH 4
// Width of one YCbCr 4:2:2 word on a channel
`define HDMI_TPM_DW 16

// ************************************************************
// Test pattern byte limits
// ************************************************************

// Limited range keeps every byte inside 10h..EBh
`define HDMI_TPM_LR_MIN 8'h10
`define HDMI_TPM_LR_MAX 8'heb
// Full range only excludes the two reserved codes 00h and FFh
`define HDMI_TPM_FR_MIN 8'h01
`define HDMI_TPM_FR_MAX 8'hfe

// Width of the per-frame pixel counter and the frame counters
`define HDMI_TPM_CNT_W 16

`endif

/* verilog/hdmi_tpm_pkg.sv */
package hdmi_tpm_pkg;

  // ************************************************************
  // Embedded sync decoder
  // ************************************************************

  // Progress through the FFFFh, 0000h, 0000h preamble on channel 0
  // The XY word is expected in the cycle after ES_00B
  typedef enum logic [1:0] {
    ES_IDLE = 2'd0,
    ES_FF   = 2'd1,
    ES_00A  = 2'd2,
    ES_00B  = 2'd3
  } es_state_t;

  // ************************************************************
  // Pattern checker results
  // ************************************************************

  // Range that a whole frame matched
  // Limited wins when a frame happens to satisfy both patterns
  typedef enum logic [1:0] {
    RANGE_NONE    = 2'd0,
    RANGE_LIMITED = 2'd1,
    RANGE_FULL    = 2'd2
  } tpm_range_t;

endpackage

/* verilog/tpm_result_if.sv */
`include "hdmi_tpm_defines.svh"

// Result of one channel for one frame, from a checker to the collector
interface tpm_result_if;
  import hdmi_tpm_pkg::*;

  // One-cycle pulse when a frame result is valid
  logic                       done;
  // Frame matched neither the limited nor the full range pattern
  logic                       oos;
  // Range the frame matched
  tpm_range_t                 range;
  // Number of enabled words in the frame
  logic [`HDMI_TPM_CNT_W-1:0] pixels;

  // The checker side drives everything
  modport chk (output done, output oos, output range, output pixels);

  // The collector side only samples, and only while done is high
  modport collector (input done, input oos, input range, input pixels);

endinterface

/* verilog/hdmi_es_decoder.sv */
`include "hdmi_tpm_defines.svh"

module hdmi_es_decoder (
  input  logic                                        hdmi_clk,
  input  logic                                        arst_n,
  input  logic [`HDMI_TPM_NUM_CH*`HDMI_TPM_DW-1:0] data_in,
  output logic [`HDMI_TPM_NUM_CH*`HDMI_TPM_DW-1:0] data_out,
  output logic                                        sof,
  output logic                                        de
);
  import hdmi_tpm_pkg::*;

  localparam int W   = `HDMI_TPM_NUM_CH * `HDMI_TPM_DW;
  localparam int DLY = 4;

  // Channel 0 word as seen at the input
  logic [`HDMI_TPM_DW-1:0] word0;
  // Preamble tracking
  es_state_t state;
  es_state_t state_nxt;
  // The current input word is the XY word of a timing code
  logic code_hit;
  logic xy_v;
  logic xy_h;
  // Words after the last code are active video
  logic active;
  // The last code seen carried V=1
  logic v_blank;
  // This code is the SAV that opens a new frame
  logic sof_tag;

  // Delay line for all channels, plus enable and frame start tags that
  // travel next to the data
  logic [W-1:0]   dly [DLY];
  logic [DLY-1:0] en_pipe;
  logic [DLY-1:0] sf_pipe;

  assign word0 = data_in[`HDMI_TPM_DW-1:0];

  // ************************************************************
  // Timing code detection on channel 0
  // ************************************************************

  always_comb begin
    state_nxt = ES_IDLE;
    case (state)
      ES_IDLE: state_nxt = (word0 == 16'hffff) ? ES_FF : ES_IDLE;
      ES_FF: begin
        if (word0 == 16'h0000)
          state_nxt = ES_00A;
        else if (word0 == 16'hffff)
          state_nxt = ES_FF;
      end
      ES_00A: begin
        if (word0 == 16'h0000)
          state_nxt = ES_00B;
        else if (word0 == 16'hffff)
          state_nxt = ES_FF;
      end
      // The word after the second 0000h is always taken as XY
      default: state_nxt = ES_IDLE;
    endcase
  end

  always_ff @(posedge hdmi_clk or negedge arst_n) begin
    if (!arst_n)
      state <= ES_IDLE;
    else
      state <= state_nxt;
  end

  // XY repeats in both bytes, so the low byte is enough
  assign code_hit = (state == ES_00B);
  assign xy_v     = word0[5];
  assign xy_h     = word0[4];
  assign sof_tag  = code_hit & ~xy_h & ~xy_v & v_blank;

  always_ff @(posedge hdmi_clk or negedge arst_n) begin
    if (!arst_n) begin
      active  <= 1'b0;
      v_blank <= 1'b0;
    end else if (code_hit) begin
      // Only an SAV in the active field opens a run of enabled words
      active <= ~xy_h & ~xy_v;
      if (xy_v)
        v_blank <= 1'b1;
      else if (sof_tag)
        v_blank <= 1'b0;
    end
  end

  // ************************************************************
  // Four word delay line with aligned tags
  // ************************************************************

  always_ff @(posedge hdmi_clk) begin
    dly[0] <= data_in;
    for (int i = 1; i < DLY; i++)
      dly[i] <= dly[i-1];
  end

  // The preamble is only recognised once XY arrives, so its three words
  // are already in the pipe with the old active tag
  // Wiping all enable tags on a hit removes them before they reach the output
  always_ff @(posedge hdmi_clk or negedge arst_n) begin
    if (!arst_n) begin
      en_pipe <= '0;
      sf_pipe <= '0;
    end else begin
      if (code_hit)
        en_pipe <= '0;
      else
        en_pipe <= {en_pipe[DLY-2:0], active};
      sf_pipe <= {sf_pipe[DLY-2:0], sof_tag};
    end
  end

  assign data_out = dly[DLY-1];
  assign de       = en_pipe[DLY-1];
  assign sof      = sf_pipe[DLY-1];

  // Frame start sits on an XY word, which is never enabled
  a_sof_de_excl: assert property (@(posedge hdmi_clk) disable iff (!arst_n)
    !(sof && de));

  // The preamble start word must never leak out as video
  a_de_no_preamble: assert property (@(posedge hdmi_clk) disable iff (!arst_n)
    de |-> (data_out[`HDMI_TPM_DW-1:0] != {`HDMI_TPM_DW{1'b1}}));

endmodule

/* verilog/hdmi_tpm_checker.sv */
`include "hdmi_tpm_defines.svh"

module hdmi_tpm_checker (
  input  logic                    hdmi_clk,
  input  logic                    arst_n,
  input  logic                    sof,
  input  logic                    de,
  input  logic [`HDMI_TPM_DW-1:0] data,
  tpm_result_if.chk               result
);
  import hdmi_tpm_pkg::*;

  // Pixel index inside the current frame
  logic [`HDMI_TPM_CNT_W-1:0] pix_cnt;
  // Expected words for both patterns
  logic [`HDMI_TPM_DW-1:0]    exp_lr;
  logic [`HDMI_TPM_DW-1:0]    exp_fr;
  // Sticky mismatch flags of the frame in progress
  logic                       lr_mm;
  logic                       fr_mm;
  // First frame start after reset only opens the first frame
  logic                       armed;
  // Registered frame result
  logic                       done_q;
  logic                       oos_q;
  tpm_range_t                 range_q;
  logic [`HDMI_TPM_CNT_W-1:0] pixels_q;

  // Clamp every byte of the pattern index separately
  function automatic logic [`HDMI_TPM_DW-1:0] clamp_word(
    input logic [`HDMI_TPM_DW-1:0] idx,
    input logic [7:0]              lo,
    input logic [7:0]              hi
  );
    logic [`HDMI_TPM_DW-1:0] w;
    logic [7:0]              b;
    for (int i = 0; i < `HDMI_TPM_DW / 8; i++) begin
      b = idx[8*i +: 8];
      if (b < lo)
        b = lo;
      else if (b > hi)
        b = hi;
      w[8*i +: 8] = b;
    end
    return w;
  endfunction

  assign exp_lr = clamp_word(pix_cnt[`HDMI_TPM_DW-1:0], `HDMI_TPM_LR_MIN, `HDMI_TPM_LR_MAX);
  assign exp_fr = clamp_word(pix_cnt[`HDMI_TPM_DW-1:0], `HDMI_TPM_FR_MIN, `HDMI_TPM_FR_MAX);

  // ************************************************************
  // Frame accumulation
  // ************************************************************

  always_ff @(posedge hdmi_clk or negedge arst_n) begin
    if (!arst_n) begin
      armed   <= 1'b0;
      done_q  <= 1'b0;
      pix_cnt <= '0;
      lr_mm   <= 1'b0;
      fr_mm   <= 1'b0;
    end else begin
      done_q <= sof & armed;
      if (sof) begin
        // Restart the pattern at index zero for the new frame
        armed   <= 1'b1;
        pix_cnt <= '0;
        lr_mm   <= 1'b0;
        fr_mm   <= 1'b0;
      end else if (de) begin
        pix_cnt <= pix_cnt + 1'b1;
        lr_mm   <= lr_mm | (data != exp_lr);
        fr_mm   <= fr_mm | (data != exp_fr);
      end
    end
  end

  // Result of the frame that just ended is valid together with done
  always_ff @(posedge hdmi_clk or negedge arst_n) begin
    if (!arst_n) begin
      oos_q    <= 1'b0;
      pixels_q <= '0;
      range_q  <= RANGE_NONE;
    end else if (sof) begin
      oos_q    <= lr_mm & fr_mm;
      pixels_q <= pix_cnt;
      if (!lr_mm)
        range_q <= RANGE_LIMITED;
      else if (!fr_mm)
        range_q <= RANGE_FULL;
      else
        range_q <= RANGE_NONE;
    end
  end

  assign result.done   = done_q;
  assign result.oos    = oos_q;
  assign result.range  = range_q;
  assign result.pixels = pixels_q;

endmodule

/* verilog/tpm_status_collector.sv */
`include "hdmi_tpm_defines.svh"

module tpm_status_collector (
  input  logic                           hdmi_clk,
  input  logic                           arst_n,
  input  logic                           clear,
  tpm_result_if.collector                results [`HDMI_TPM_NUM_CH],
  output logic [`HDMI_TPM_NUM_CH-1:0]   oos,
  output logic [`HDMI_TPM_NUM_CH-1:0]   oos_sticky,
  output logic                           in_sync,
  output logic [2*`HDMI_TPM_NUM_CH-1:0] range,
  output logic [`HDMI_TPM_CNT_W-1:0]    frame_count,
  output logic [`HDMI_TPM_CNT_W-1:0]    error_frames,
  output logic [`HDMI_TPM_CNT_W-1:0]    frame_pixels
);
  import hdmi_tpm_pkg::*;

  localparam int N = `HDMI_TPM_NUM_CH;

  // Checker results gathered into flat vectors
  logic [N-1:0]               done_v;
  logic [N-1:0]               oos_v;
  logic [2*N-1:0]             range_v;
  logic [`HDMI_TPM_CNT_W-1:0] pixels0;
  logic                       done_any;
  // At least one frame has been reported since reset
  logic                       seen;
  // Values that a done in this cycle builds on, after a pending clear
  logic [N-1:0]               sticky_base;
  logic [`HDMI_TPM_CNT_W-1:0] fc_base;
  logic [`HDMI_TPM_CNT_W-1:0] ef_base;

  // Counters stop at all ones rather than wrap
  function automatic logic [`HDMI_TPM_CNT_W-1:0] sat_inc(
    input logic [`HDMI_TPM_CNT_W-1:0] v
  );
    return (&v) ? v : v + 1'b1;
  endfunction

  for (genvar g = 0; g < N; g++) begin : g_ch
    assign done_v[g]        = results[g].done;
    assign oos_v[g]         = results[g].oos;
    assign range_v[2*g +: 2] = results[g].range;
  end

  assign pixels0  = results[0].pixels;
  assign done_any = |done_v;

  // ************************************************************
  // Status registers
  // ************************************************************

  assign sticky_base = clear ? '0 : oos_sticky;
  assign fc_base     = clear ? '0 : frame_count;
  assign ef_base     = clear ? '0 : error_frames;

  always_ff @(posedge hdmi_clk or negedge arst_n) begin
    if (!arst_n) begin
      oos          <= '0;
      oos_sticky   <= '0;
      range        <= {N{RANGE_NONE}};
      frame_count  <= '0;
      error_frames <= '0;
      frame_pixels <= '0;
      seen         <= 1'b0;
    end else begin
      // A clear in the same cycle as done still lets that frame count
      oos_sticky   <= sticky_base;
      frame_count  <= fc_base;
      error_frames <= ef_base;
      if (done_any) begin
        seen         <= 1'b1;
        oos          <= oos_v;
        range        <= range_v;
        frame_pixels <= pixels0;
        oos_sticky   <= sticky_base | oos_v;
        frame_count  <= sat_inc(fc_base);
        if (|oos_v)
          error_frames <= sat_inc(ef_base);
      end
    end
  end

  // Live sync needs a reported frame and no channel out of sync
  assign in_sync = seen & ~(|oos);

  // All checkers see the same frame start, so their reports line up
  a_done_aligned: assert property (@(posedge hdmi_clk) disable iff (!arst_n)
    (|done_v) |-> (&done_v));

endmodule

/* verilog/hdmi_rx_tpm_top.sv */
`include "hdmi_tpm_defines.svh"

module hdmi_rx_tpm_top (
  input  logic                                        hdmi_clk,
  input  logic                                        arst_n,
  input  logic [`HDMI_TPM_NUM_CH*`HDMI_TPM_DW-1:0] hdmi_data,
  input  logic                                        clear,
  output logic [`HDMI_TPM_NUM_CH-1:0]                oos,
  output logic [`HDMI_TPM_NUM_CH-1:0]                oos_sticky,
  output logic                                        in_sync,
  output logic [2*`HDMI_TPM_NUM_CH-1:0]              range,
  output logic [`HDMI_TPM_CNT_W-1:0]                 frame_count,
  output logic [`HDMI_TPM_CNT_W-1:0]                 error_frames,
  output logic [`HDMI_TPM_CNT_W-1:0]                 frame_pixels
);

  // Aligned stream from the decoder
  logic [`HDMI_TPM_NUM_CH*`HDMI_TPM_DW-1:0] data_dly;
  logic                                        sof;
  logic                                        de;

  // One result bundle per channel
  tpm_result_if res_if [`HDMI_TPM_NUM_CH] ();

  // Timing codes come from channel 0 only
  hdmi_es_decoder u_decoder (
    .hdmi_clk (hdmi_clk),
    .arst_n   (arst_n),
    .data_in  (hdmi_data),
    .data_out (data_dly),
    .sof      (sof),
    .de       (de)
  );

  // ************************************************************
  // Per-channel pattern checkers
  // ************************************************************

  for (genvar g = 0; g < `HDMI_TPM_NUM_CH; g++) begin : g_chk
    hdmi_tpm_checker u_checker (
      .hdmi_clk (hdmi_clk),
      .arst_n   (arst_n),
      .sof      (sof),
      .de       (de),
      .data     (data_dly[g*`HDMI_TPM_DW +: `HDMI_TPM_DW]),
      .result   (res_if[g])
    );
  end

  tpm_status_collector u_collector (
    .hdmi_clk     (hdmi_clk),
    .arst_n       (arst_n),
    .clear        (clear),
    .results      (res_if),
    .oos          (oos),
    .oos_sticky   (oos_sticky),
    .in_sync      (in_sync),
    .range        (range),
    .frame_count  (frame_count),
    .error_frames (error_frames),
    .frame_pixels (frame_pixels)
  );

endmodule

/* tb/tb_hdmi_rx_tpm.sv */
`include "hdmi_tpm_defines.svh"

module tb_hdmi_rx_tpm;
  import hdmi_tpm_pkg::*;

  localparam int N          = `HDMI_TPM_NUM_CH;
  localparam int DW         = `HDMI_TPM_DW;
  // Frame geometry of the generated stream
  localparam int LINE_PIX   = 64;
  localparam int ACT_LINES  = 4;
  localparam int BLK_LINES  = 2;
  localparam int HBLANK     = 4;
  localparam int FRAME_PIX  = ACT_LINES * LINE_PIX;
  localparam int WAIT_LIMIT = 2000;
  // Neutral blanking word that is never part of a preamble
  localparam logic [DW-1:0] BLANK_WORD = 16'h1080;

  logic                       hdmi_clk;
  logic                       arst_n;
  logic [N*DW-1:0]            hdmi_data;
  logic                       clear;
  logic [N-1:0]               oos;
  logic [N-1:0]               oos_sticky;
  logic                       in_sync;
  logic [2*N-1:0]             range;
  logic [`HDMI_TPM_CNT_W-1:0] frame_count;
  logic [`HDMI_TPM_CNT_W-1:0] error_frames;
  logic [`HDMI_TPM_CNT_W-1:0] frame_pixels;

  // Running totals for the closing summary
  int errors;
  int checks;
  int tests;
  // Expected frame counter value tracked across tests
  int exp_fc;

  hdmi_rx_tpm_top DUT (
    .hdmi_clk     (hdmi_clk),
    .arst_n       (arst_n),
    .hdmi_data    (hdmi_data),
    .clear        (clear),
    .oos          (oos),
    .oos_sticky   (oos_sticky),
    .in_sync      (in_sync),
    .range        (range),
    .frame_count  (frame_count),
    .error_frames (error_frames),
    .frame_pixels (frame_pixels)
  );

  initial hdmi_clk = 1'b0;
  always #4 hdmi_clk = ~hdmi_clk;

  // ************************************************************
  // Reference pattern model
  // ************************************************************

  function automatic logic [7:0] clamp_byte(input logic [7:0] b, input logic [7:0] lo,
                                            input logic [7:0] hi);
    if (b < lo)
      return lo;
    if (b > hi)
      return hi;
    return b;
  endfunction

  // Expected word for a frame pixel index with each byte clamped on its own
  function automatic logic [DW-1:0] pattern_word(input logic [15:0] idx, input logic full);
    logic [7:0] lo;
    logic [7:0] hi;
    lo = full ? `HDMI_TPM_FR_MIN : `HDMI_TPM_LR_MIN;
    hi = full ? `HDMI_TPM_FR_MAX : `HDMI_TPM_LR_MAX;
    return {clamp_byte(idx[15:8], lo, hi), clamp_byte(idx[7:0], lo, hi)};
  endfunction

  // XY word with protection bits where F is always 0 for progressive video
  function automatic logic [DW-1:0] code_xy(input logic v, input logic h);
    logic [7:0] xy;
    xy = {1'b1, 1'b0, v, h, v ^ h, h, v, v ^ h};
    return {xy, xy};
  endfunction

  // Range field for all channels where one channel may differ
  function automatic logic [2*N-1:0] range_vec(input int ch, input tpm_range_t r_ch,
                                               input tpm_range_t r_rest);
    logic [2*N-1:0] v;
    for (int c = 0; c < N; c++)
      v[2*c +: 2] = (c == ch) ? r_ch : r_rest;
    return v;
  endfunction

  // ************************************************************
  // Stream generator
  // ************************************************************

  task automatic drive_word(input logic [N*DW-1:0] w);
    @(posedge hdmi_clk);
    hdmi_data <= w;
  endtask

  // Timing codes and blanking are the same on every channel
  task automatic drive_all(input logic [DW-1:0] w);
    drive_word({N{w}});
  endtask

  task automatic send_code(input logic v, input logic h);
    drive_all(16'hffff);
    drive_all(16'h0000);
    drive_all(16'h0000);
    drive_all(code_xy(v, h));
  endtask

  // One line is EAV, horizontal blanking, SAV and then 64 words
  task automatic send_line(input logic v, input int first_idx, input logic [N-1:0] full_mask,
                           input int bad_ch, input int bad_pix);
    logic [N*DW-1:0] w;
    int              idx;
    send_code(v, 1'b1);
    repeat (HBLANK) drive_all(BLANK_WORD);
    send_code(v, 1'b0);
    for (int p = 0; p < LINE_PIX; p++) begin
      idx = first_idx + p;
      for (int c = 0; c < N; c++) begin
        if (v)
          w[c*DW +: DW] = BLANK_WORD;
        else if (c == bad_ch && idx == bad_pix)
          w[c*DW +: DW] = '0;
        else
          w[c*DW +: DW] = pattern_word(idx[15:0], full_mask[c]);
      end
      drive_word(w);
    end
  endtask

  // A bad_ch of -1 leaves every channel clean
  task automatic send_frame(input logic [N-1:0] full_mask, input int bad_ch, input int bad_pix);
    for (int l = 0; l < BLK_LINES; l++)
      send_line(1'b1, 0, full_mask, bad_ch, bad_pix);
    for (int l = 0; l < ACT_LINES; l++)
      send_line(1'b0, l * LINE_PIX, full_mask, bad_ch, bad_pix);
    // A trailing V=1 code keeps idle cycles out of the next frame
    send_code(1'b1, 1'b1);
    drive_all(BLANK_WORD);
  endtask

  // ************************************************************
  // Checking helpers
  // ************************************************************

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h at time %0t", name, got, exp, $time);
    end
  endtask

  // Outputs are sampled on the falling edge away from the driving edge
  task automatic wait_count(input int target);
    int cycles;
    cycles = 0;
    @(negedge hdmi_clk);
    while (frame_count < target && cycles < WAIT_LIMIT) begin
      @(negedge hdmi_clk);
      cycles++;
    end
    if (frame_count < target) begin
      errors++;
      $display("Timeout: frame_count did not reach %0d within %0d cycles", target, WAIT_LIMIT);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("%s finished with %0d errors", name, errors - err_before);
  endtask

  // ************************************************************
  // Directed tests
  // ************************************************************

  task automatic check_reset_state();
    int e0;
    e0 = errors;
    @(negedge hdmi_clk);
    expect_eq("oos", oos, 0);
    expect_eq("oos_sticky", oos_sticky, 0);
    expect_eq("in_sync", in_sync, 0);
    expect_eq("range", range, range_vec(-1, RANGE_NONE, RANGE_NONE));
    expect_eq("frame_count", frame_count, 0);
    expect_eq("error_frames", error_frames, 0);
    expect_eq("frame_pixels", frame_pixels, 0);
    report_test("reset state", e0);
  endtask

  // The first frame only arms the checkers, so three frames give two reports
  task automatic sync_on_limited_frames();
    int e0;
    e0 = errors;
    repeat (3) send_frame('0, -1, 0);
    exp_fc = 2;
    wait_count(exp_fc);
    expect_eq("frame_count", frame_count, 2);
    expect_eq("oos", oos, 0);
    expect_eq("in_sync", in_sync, 1);
    expect_eq("range", range, range_vec(-1, RANGE_LIMITED, RANGE_LIMITED));
    expect_eq("frame_pixels", frame_pixels, FRAME_PIX);
    expect_eq("error_frames", error_frames, 0);
    report_test("limited range frames", e0);
  endtask

  // Each report covers the frame sent before it, so the second frame is needed
  task automatic detect_full_range_channel();
    int e0;
    e0 = errors;
    send_frame(N'(2), -1, 0);
    send_frame(N'(2), -1, 0);
    exp_fc += 2;
    wait_count(exp_fc);
    expect_eq("range", range, range_vec(1, RANGE_FULL, RANGE_LIMITED));
    expect_eq("oos", oos, 0);
    expect_eq("in_sync", in_sync, 1);
    report_test("full range channel", e0);
  endtask

  task automatic flag_corrupted_channel();
    int e0;
    e0 = errors;
    send_frame('0, 2, 5);
    send_frame('0, -1, 0);
    exp_fc += 2;
    wait_count(exp_fc);
    expect_eq("oos", oos, 4'b0100);
    expect_eq("oos_sticky", oos_sticky, 4'b0100);
    expect_eq("range", range, range_vec(2, RANGE_NONE, RANGE_LIMITED));
    expect_eq("error_frames", error_frames, 1);
    expect_eq("in_sync", in_sync, 0);
    // The clean frame brings live sync back but not the sticky flag
    send_frame('0, -1, 0);
    exp_fc += 1;
    wait_count(exp_fc);
    expect_eq("oos", oos, 0);
    expect_eq("oos_sticky", oos_sticky, 4'b0100);
    expect_eq("in_sync", in_sync, 1);
    expect_eq("error_frames", error_frames, 1);
    report_test("corrupted channel", e0);
  endtask

  task automatic clear_status();
    int e0;
    e0 = errors;
    @(posedge hdmi_clk);
    clear <= 1'b1;
    @(posedge hdmi_clk);
    clear <= 1'b0;
    @(negedge hdmi_clk);
    exp_fc = 0;
    expect_eq("oos_sticky", oos_sticky, 0);
    expect_eq("frame_count", frame_count, 0);
    expect_eq("error_frames", error_frames, 0);
    report_test("clear", e0);
  endtask

  // The first report here still belongs to the last clean frame
  task automatic count_random_errors();
    int e0;
    int ch;
    int pix;
    int prev_ch;
    e0 = errors;
    prev_ch = -1;
    for (int i = 0; i < 8; i++) begin
      ch  = int'($urandom % N);
      pix = int'($urandom % FRAME_PIX);
      send_frame('0, ch, pix);
      exp_fc += 1;
      wait_count(exp_fc);
      if (i == 0)
        expect_eq("oos", oos, 0);
      else
        expect_eq("oos", oos, 1 << prev_ch);
      expect_eq("error_frames", error_frames, i);
      prev_ch = ch;
    end
    // One more clean frame flushes out the report of the eighth
    send_frame('0, -1, 0);
    exp_fc += 1;
    wait_count(exp_fc);
    expect_eq("oos", oos, 1 << prev_ch);
    expect_eq("error_frames", error_frames, 8);
    expect_eq("frame_count", frame_count, 9);
    report_test("random errors", e0);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    tests  = 0;
    exp_fc = 0;
    void'($urandom(32'h7f4c1661));
    arst_n    <= 1'b0;
    clear     <= 1'b0;
    hdmi_data <= {N{BLANK_WORD}};
    repeat (16) @(posedge hdmi_clk);
    arst_n <= 1'b1;

    check_reset_state();
    sync_on_limited_frames();
    detect_full_range_channel();
    flag_corrupted_channel();
    clear_status();
    count_random_errors();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
verilog/hdmi_tpm_pkg.sv
verilog/tpm_result_if.sv
verilog/hdmi_es_decoder.sv
verilog/hdmi_tpm_checker.sv
verilog/tpm_status_collector.sv
verilog/hdmi_rx_tpm_top.sv
tb/tb_hdmi_rx_tpm.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_hdmi_rx_tpm -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee "$LOG" \
  || { echo "Build or simulation did not complete"; exit 1; }

[ -s "$LOG" ] || { echo "Simulation log is empty"; exit 1; }

grep -q "TEST RESULT: FAIL" "$LOG" \
  && { echo "Simulation reported failures"; exit 1; } \
  || { echo "Simulation finished without failures"; exit 0; }
